// File: Bender.yml
package:
  name: kicker_video

sources:
  # packages first, then leaf modules up to the top
  - hw/video_pkg.sv
  - hw/palette_pkg.sv
  - hw/pixel_if.sv
  - hw/palette_prom.sv
  - hw/blank_delay.sv
  - hw/kicker_colmix.sv
  - hw/kicker_video_top.sv

  # testbench, reads bench/kicker_video_tests.txt at run time
  - target: test
    files:
      - bench/kicker_video_tb.sv

// File: bench/kicker_video_tb.sv
/*
 * Self-checking testbench for the Kicker colour mixer top.
 * Reads PROM writes and pixel records from the tests file, fills the
 * unused PROM entries with random data, streams the pixels on pxl_cen
 * and compares the colour and delayed blanking with the expected values.
 */

`timescale 1ns/1ps

module kicker_video_tb;

    // ########################################################################
    // constants and types
    // ########################################################################

    localparam int clk_half   = 50;                         // 100 ns clock
    localparam int poll_ns    = 5;                          // polls fall 1 ns after edges
    localparam int polls_clk  = 2 * clk_half / poll_ns;
    localparam int reset_clks = 5;
    localparam int prom_depth = 1 << palette_pkg::prom_aw;
    localparam int seed       = 87168;
    localparam     tests_path = "bench/kicker_video_tests.txt";

    // one slot per pxl_cen tick, valid only for file pixels
    typedef struct packed {
        logic                          valid;
        logic [palette_pkg::col_w-1:0] r;
        logic [palette_pkg::col_w-1:0] g;
        logic [palette_pkg::col_w-1:0] b;
        logic                          lhbl;
        logic                          lvbl;
    } expect_t;

    // DUT signals
    logic                              clk;
    logic                              reset;
    logic                              pxl_cen;
    logic [video_pkg::layer_w-1:0]     obj_pxl;
    logic [video_pkg::layer_w-1:0]     scr_pxl;
    logic                              lhbl;
    logic                              lvbl;
    logic [palette_pkg::pal_sel_w-1:0] pal_sel;
    logic [video_pkg::gfx_en_w-1:0]    gfx_en;
    logic [palette_pkg::col_w-1:0]     prog_data;
    logic [palette_pkg::prom_aw-1:0]   prog_addr;
    logic [palette_pkg::chan_n-1:0]    prog_en;
    logic [palette_pkg::col_w-1:0]     red;
    logic [palette_pkg::col_w-1:0]     green;
    logic [palette_pkg::col_w-1:0]     blue;
    logic                              lhbl_dly;
    logic                              lvbl_dly;

    expect_t     exp_q [$];                                 // in-flight pixels, oldest first
    int          cycle_cnt  = 0;
    int          errors     = 0;
    int          checks     = 0;
    int          px_checked = 0;
    int          x_records  = 0;
    int          fd;
    int unsigned rnd;
    bit          timed_out  = 1'b0;
    bit          used [palette_pkg::chan_n][prom_depth];    // entries named by the file

    always #clk_half clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    kicker_video_top u_dut (
        .clk       (clk),
        .reset     (reset),
        .pxl_cen   (pxl_cen),
        .obj_pxl   (obj_pxl),
        .scr_pxl   (scr_pxl),
        .lhbl      (lhbl),
        .lvbl      (lvbl),
        .pal_sel   (pal_sel),
        .gfx_en    (gfx_en),
        .prog_data (prog_data),
        .prog_addr (prog_addr),
        .prog_en   (prog_en),
        .red       (red),
        .green     (green),
        .blue      (blue),
        .lhbl_dly  (lhbl_dly),
        .lvbl_dly  (lvbl_dly)
    );

    // ########################################################################
    // clocking and checking
    // ########################################################################

    // returns 1 ns after the n-th rising edge
    task automatic wait_clocks(input int n);
        int start;
        int polls;
        start = cycle_cnt;
        polls = 0;
        while (!timed_out && (cycle_cnt - start) < n && polls < (n + 2) * polls_clk) begin
            #poll_ns;
            polls++;
        end
        if (!timed_out && (cycle_cnt - start) < n) begin
            $display("timeout at %0t: clock stalled, %0d of %0d edges seen",
                     $time, cycle_cnt - start, n);
            timed_out = 1'b1;
            errors++;
        end
    endtask

    task automatic check_outputs(input expect_t e);
        checks++;
        if (red !== e.r) begin
            $display("MISMATCH t=%0t red expected %h got %h", $time, e.r, red);
            errors++;
        end
        if (green !== e.g) begin
            $display("MISMATCH t=%0t green expected %h got %h", $time, e.g, green);
            errors++;
        end
        if (blue !== e.b) begin
            $display("MISMATCH t=%0t blue expected %h got %h", $time, e.b, blue);
            errors++;
        end
        if (lhbl_dly !== e.lhbl) begin
            $display("MISMATCH t=%0t lhbl_dly expected %b got %b", $time, e.lhbl, lhbl_dly);
            errors++;
        end
        if (lvbl_dly !== e.lvbl) begin
            $display("MISMATCH t=%0t lvbl_dly expected %b got %b", $time, e.lvbl, lvbl_dly);
            errors++;
        end
    endtask

    // three idle clocks, then one with pxl_cen high
    task automatic pixel_tick(input expect_t e);
        expect_t old;
        wait_clocks(3);
        pxl_cen = 1'b1;
        wait_clocks(1);
        pxl_cen = 1'b0;
        exp_q.push_back(e);
        // output now shows the pixel sampled pipe_depth-1 ticks ago
        if (exp_q.size() == video_pkg::pipe_depth) begin
            old = exp_q.pop_front();
            if (old.valid && !timed_out) begin
                px_checked++;
                check_outputs(old);
            end
        end
    endtask

    function automatic bit pending_checks();
        foreach (exp_q[i]) begin
            if (exp_q[i].valid) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic drain_pipeline();
        expect_t idle;
        idle = '0;  // junk slot, never checked
        while (!timed_out && pending_checks()) begin
            pixel_tick(idle);
        end
    endtask

    task automatic prom_write(input int chan, input logic [palette_pkg::prom_aw-1:0] addr,
                              input logic [palette_pkg::col_w-1:0] data);
        prog_en       = '0;
        prog_en[chan] = 1'b1;  // one channel only
        prog_addr     = addr;
        prog_data     = data;
        wait_clocks(1);
        prog_en       = '0;
    endtask

    // ########################################################################
    // tests file
    // ########################################################################

    // first pass, marks the PROM entries the file programs
    task automatic scan_used();
        logic [63:0]                     kind;
        logic [8*256-1:0]                line_buf;
        int                              rc;
        int                              chan;
        logic [palette_pkg::prom_aw-1:0] addr;
        logic [palette_pkg::col_w-1:0]   data;
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "P") begin
                rc = $fscanf(fd, "%h %h %h", chan, addr, data);
                if (rc == 3 && chan >= 0 && chan < palette_pkg::chan_n) begin
                    used[chan][addr] = 1'b1;
                end
            end else begin
                rc = $fgets(line_buf, fd);  // comment or pixel, skipped here
            end
        end
    endtask

    task automatic fill_unused();
        int unsigned r;
        for (int ch = 0; ch < palette_pkg::chan_n; ch++) begin
            for (int a = 0; a < prom_depth; a++) begin
                if (!used[ch][a]) begin
                    r = $urandom;
                    prom_write(ch, a[palette_pkg::prom_aw-1:0], r[palette_pkg::col_w-1:0]);
                end
            end
        end
    endtask

    task automatic run_records();
        logic [63:0]                       kind;
        logic [8*256-1:0]                  line_buf;
        int                                rc;
        int                                chan;
        logic [palette_pkg::prom_aw-1:0]   addr;
        logic [palette_pkg::col_w-1:0]     data;
        logic [palette_pkg::pal_sel_w-1:0] f_pal;
        logic [video_pkg::gfx_en_w-1:0]    f_gfx;
        logic [video_pkg::layer_w-1:0]     f_obj;
        logic [video_pkg::layer_w-1:0]     f_scr;
        logic                              f_hb;
        logic                              f_vb;
        logic [palette_pkg::col_w-1:0]     f_r;
        logic [palette_pkg::col_w-1:0]     f_g;
        logic [palette_pkg::col_w-1:0]     f_b;
        logic                              f_ehb;
        logic                              f_evb;
        expect_t                           e;
        while (!timed_out && $fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                rc = $fgets(line_buf, fd);
            end else if (kind == "P") begin
                rc = $fscanf(fd, "%h %h %h", chan, addr, data);
                if (rc != 3 || chan < 0 || chan >= palette_pkg::chan_n) begin
                    $display("malformed PROM record in %s", tests_path);
                    errors++;
                end else begin
                    drain_pipeline();  // earlier lookups see the old entry
                    prom_write(chan, addr, data);
                end
            end else if (kind == "X") begin
                rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h", f_pal, f_gfx,
                             f_obj, f_scr, f_hb, f_vb, f_r, f_g, f_b, f_ehb, f_evb);
                if (rc != 11) begin
                    $display("malformed pixel record in %s", tests_path);
                    errors++;
                end else begin
                    x_records++;
                    pal_sel = f_pal;
                    gfx_en  = f_gfx;
                    obj_pxl = f_obj;
                    scr_pxl = f_scr;
                    lhbl    = f_hb;
                    lvbl    = f_vb;
                    e       = {1'b1, f_r, f_g, f_b, f_ehb, f_evb};
                    pixel_tick(e);
                end
            end else begin
                $display("unknown record type in %s", tests_path);
                errors++;
                rc = $fgets(line_buf, fd);
            end
        end
    endtask

    // ########################################################################
    // main sequence
    // ########################################################################

    initial begin
        clk       = 1'b0;
        reset     = 1'b1;
        pxl_cen   = 1'b0;
        obj_pxl   = '0;
        scr_pxl   = '0;
        lhbl      = 1'b0;
        lvbl      = 1'b0;
        pal_sel   = '0;
        gfx_en    = '1;
        prog_data = '0;
        prog_addr = '0;
        prog_en   = '0;
        rnd       = $urandom(seed);
        #1;  // keep polls off the clock edges
        wait_clocks(reset_clks);
        reset = 1'b0;
        check_outputs('0);  // black and blanking before any pxl_cen
        fd = $fopen(tests_path, "r");
        if (fd == 0) begin
            $display("cannot open %s", tests_path);
            errors++;
        end else begin
            scan_used();
            $fclose(fd);
            fill_unused();
            fd = $fopen(tests_path, "r");
            run_records();
            $fclose(fd);
            drain_pipeline();
        end
        if (px_checked != x_records) begin
            $display("only %0d of %0d pixels reached the output", px_checked, x_records);
            errors++;
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: bench/kicker_video_tests.txt
# P chan addr data : PROM write, chan 0 red 1 green 2 blue, fields in hex
# X pal gfx obj scr lhbl lvbl exp_r exp_g exp_b exp_lhbl exp_lvbl : pixel and expected output
# bank 1 sprite 5, address 25
P 0 25 a
P 1 25 3
P 2 25 7
# bank 1 scroll c, address 3c
P 0 3c 2
P 1 3c e
P 2 3c 9
# bank 1 scroll with code forced to 0, address 30
P 0 30 6
P 1 30 1
P 2 30 d
# bank 7 sprite 9 and scroll 3
P 0 e9 f
P 1 e9 8
P 2 e9 4
P 0 f3 5
P 1 f3 b
P 2 f3 c
# bank 0 scroll 0 and bank 2 sprite a
P 0 10 1
P 1 10 2
P 2 10 3
P 0 4a c
P 1 4a d
P 2 4a e
# sprite priority, transparent sprite, debug gating
X 1 f 5 c 1 1 a 3 7 1 1
X 7 f 9 3 1 1 f 8 4 1 1
X 1 f 0 c 1 1 2 e 9 1 1
X 1 7 5 c 1 1 2 e 9 1 1
X 7 7 9 3 1 1 5 b c 1 1
X 1 1 5 c 1 1 2 e 9 1 1
X 1 6 5 c 1 1 6 1 d 1 1
X 1 e 0 c 1 1 6 1 d 1 1
X 1 9 5 c 1 1 a 3 7 1 1
# blanking forces black
X 1 f 5 c 0 1 0 0 0 0 1
X 1 f 5 c 1 0 0 0 0 1 0
X 7 f 9 3 0 0 0 0 0 0 0
X 1 f 5 c 1 1 a 3 7 1 1
X 0 f 0 0 1 1 1 2 3 1 1
X 2 f a 0 1 1 c d e 1 1
# single channel rewrites
P 0 4a 3
X 2 f a 5 1 1 3 d e 1 1
P 2 25 0
X 1 f 5 c 1 1 a 3 0 1 1

// File: hw/blank_delay.sv
/*
 * Delays the blanking pair to line up with the palette lookup and
 * forces the colour to black outside the visible area.
 * Blank goes in with the pixel, colour comes in from the PROM register.
 */

`timescale 1ns/1ps

module blank_delay (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cen,        // pixel clock enable
    input  video_pkg::blank_t    blank_in,   // same tick as the pixel codes
    input  palette_pkg::rgb_t    rgb_in,     // PROM output, two ticks later
    output video_pkg::blank_t    blank_out,
    output palette_pkg::rgb_t    rgb_out
);

    // ########################################################################
    // blanking shift register
    // ########################################################################

    // one stage each for the mux and the PROM read
    localparam int dly_n = video_pkg::pipe_depth - 1;

    video_pkg::blank_t dly [dly_n];
    logic              visible;

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < dly_n; i++) begin
                dly[i] <= '0;  // blanking asserted
            end
        end else if (cen) begin
            dly[0] <= blank_in;
            for (int i = 1; i < dly_n; i++) begin
                dly[i] <= dly[i-1];
            end
        end
    end

    // both levels high means active video
    assign visible = dly[dly_n-1].lhbl && dly[dly_n-1].lvbl;

    // ########################################################################
    // output stage
    // ########################################################################

    always_ff @(posedge clk) begin
        if (reset) begin
            blank_out <= '0;
            rgb_out   <= '0;  // black
        end else if (cen) begin
            blank_out <= dly[dly_n-1];
            rgb_out   <= visible ? rgb_in : '0;  // black in blanking
        end
    end

endmodule

// File: hw/kicker_colmix.sv
/*
 * Colour mixer: sprite over scroll priority, layer debug gating,
 * palette address forming, the RGB PROM lookup and final blanking.
 * Latency is pipe_depth pxl_cen ticks from pix to rgb.
 */

`timescale 1ns/1ps

module kicker_colmix (
    input  logic                                clk,
    input  logic                                reset,
    pixel_if.sink                               pix,
    input  logic [palette_pkg::pal_sel_w-1:0]   pal_sel,    // palette bank
    input  logic [video_pkg::gfx_en_w-1:0]      gfx_en,     // layer debug enables
    input  logic [palette_pkg::col_w-1:0]       prog_data,
    input  logic [palette_pkg::prom_aw-1:0]     prog_addr,
    input  logic [palette_pkg::chan_n-1:0]      prog_en,    // one bit per channel
    output palette_pkg::rgb_t                   rgb,
    output video_pkg::blank_t                   blank_out
);

    // ########################################################################
    // layer priority
    // ########################################################################

    logic                                obj_blank;  // sprite transparent here
    logic [video_pkg::layer_w-1:0]       scr_gated;
    logic [video_pkg::layer_w:0]         mux;        // {scroll wins, code}
    logic [palette_pkg::pal_sel_w-1:0]   pal_q;      // bank, sampled with the pixel
    logic [palette_pkg::prom_aw-1:0]     pal_addr;
    palette_pkg::rgb_t                   raw;        // PROM outputs before blanking

    // code 0 is see-through, bit 3 switches sprites off
    assign obj_blank = (pix.obj_pxl == '0) || !gfx_en[3];
    // bit 0 switches the scroll layer off, bits 1 and 2 unused
    assign scr_gated = gfx_en[0] ? pix.scr_pxl : '0;

    // tick 0
    always_ff @(posedge clk) begin
        if (reset) begin
            mux   <= '0;  // bank 0, entry 0
            pal_q <= '0;
        end else if (pix.pxl_cen) begin
            mux   <= {obj_blank, obj_blank ? scr_gated : pix.obj_pxl};
            pal_q <= pal_sel;
        end
    end

    // upper half of each bank is the scroll palette
    assign pal_addr = {pal_q, mux};

    // ########################################################################
    // colour PROMs, tick 1
    // ########################################################################

    palette_prom u_red (
        .clk     (clk),
        .reset   (reset),
        .cen     (pix.pxl_cen),
        .we      (prog_en[0]),
        .wr_addr (prog_addr),
        .data    (prog_data),
        .rd_addr (pal_addr),
        .q       (raw.red)
    );

    palette_prom u_green (
        .clk     (clk),
        .reset   (reset),
        .cen     (pix.pxl_cen),
        .we      (prog_en[1]),
        .wr_addr (prog_addr),
        .data    (prog_data),
        .rd_addr (pal_addr),
        .q       (raw.green)
    );

    palette_prom u_blue (
        .clk     (clk),
        .reset   (reset),
        .cen     (pix.pxl_cen),
        .we      (prog_en[2]),
        .wr_addr (prog_addr),
        .data    (prog_data),
        .rd_addr (pal_addr),
        .q       (raw.blue)
    );

    // ########################################################################
    // blanking, tick 2
    // ########################################################################

    blank_delay u_blank (
        .clk       (clk),
        .reset     (reset),
        .cen       (pix.pxl_cen),
        .blank_in  (pix.blank),   // delayed to match mux and PROM stages
        .rgb_in    (raw),
        .blank_out (blank_out),
        .rgb_out   (rgb)
    );

endmodule

// File: hw/kicker_video_top.sv
/*
 * Top of the Kicker colour mixer with plain ports.
 * Bundles the pixel inputs onto pixel_if and splits the colour out.
 */

`timescale 1ns/1ps

module kicker_video_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                pxl_cen,    // pixel clock enable
    input  logic [video_pkg::layer_w-1:0]       obj_pxl,    // sprite code
    input  logic [video_pkg::layer_w-1:0]       scr_pxl,    // tilemap code
    input  logic                                lhbl,       // active low
    input  logic                                lvbl,       // active low
    input  logic [palette_pkg::pal_sel_w-1:0]   pal_sel,
    input  logic [video_pkg::gfx_en_w-1:0]      gfx_en,

    // PROM programming
    input  logic [palette_pkg::col_w-1:0]       prog_data,
    input  logic [palette_pkg::prom_aw-1:0]     prog_addr,
    input  logic [palette_pkg::chan_n-1:0]      prog_en,

    output logic [palette_pkg::col_w-1:0]       red,
    output logic [palette_pkg::col_w-1:0]       green,
    output logic [palette_pkg::col_w-1:0]       blue,
    output logic                                lhbl_dly,
    output logic                                lvbl_dly
);

    palette_pkg::rgb_t   rgb;
    video_pkg::blank_t   blank_dly;

    pixel_if pix_bus ();

    // pack the pixel side
    assign pix_bus.pxl_cen    = pxl_cen;
    assign pix_bus.obj_pxl    = obj_pxl;
    assign pix_bus.scr_pxl    = scr_pxl;
    assign pix_bus.blank.lhbl = lhbl;
    assign pix_bus.blank.lvbl = lvbl;

    kicker_colmix u_colmix (
        .clk       (clk),
        .reset     (reset),
        .pix       (pix_bus.sink),
        .pal_sel   (pal_sel),
        .gfx_en    (gfx_en),
        .prog_data (prog_data),
        .prog_addr (prog_addr),
        .prog_en   (prog_en),
        .rgb       (rgb),
        .blank_out (blank_dly)
    );

    // unpack the outputs
    assign red      = rgb.red;
    assign green    = rgb.green;
    assign blue     = rgb.blue;
    assign lhbl_dly = blank_dly.lhbl;
    assign lvbl_dly = blank_dly.lvbl;

endmodule

// File: hw/palette_pkg.sv
/*
 * Palette-side definitions for the Kicker colour mixer.
 * Bank select width, colour PROM geometry and the RGB triple.
 * Files use these through scoped names.
 */

package palette_pkg;

    // ########################################################################
    // colour PROMs
    // ########################################################################

    localparam int pal_sel_w = 3;  // palette bank select
    localparam int prom_aw   = 8;  // 256 entries per PROM
    localparam int col_w     = 4;  // bits per colour channel
    localparam int chan_n    = 3;  // red, green, blue

    // prog_en bit order
    // bit 0 red, bit 1 green, bit 2 blue

    // ########################################################################
    // colour output
    // ########################################################################

    typedef struct packed {
        logic [col_w-1:0] red;
        logic [col_w-1:0] green;
        logic [col_w-1:0] blue;
    } rgb_t;

endpackage

// File: hw/palette_prom.sv
/*
 * One 256x4 colour PROM, loaded through a plain write port.
 * Reads are registered on the pixel clock enable, writes happen on any clk.
 */

`timescale 1ns/1ps

module palette_prom (
    input  logic                              clk,
    input  logic                              reset,
    input  logic                              cen,      // pixel clock enable
    input  logic                              we,       // programming strobe
    input  logic [palette_pkg::prom_aw-1:0]   wr_addr,
    input  logic [palette_pkg::col_w-1:0]     data,
    input  logic [palette_pkg::prom_aw-1:0]   rd_addr,
    output logic [palette_pkg::col_w-1:0]     q
);

    localparam int depth = 1 << palette_pkg::prom_aw;

    logic [palette_pkg::col_w-1:0] mem [depth];  // colour entries

    // programming port, not tied to the pixel strobe
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= data;
        end
    end

    // lookup register, one pipeline stage
    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;  // black until the first tick
        end else if (cen) begin
            q <= mem[rd_addr];
        end
    end

endmodule

// File: hw/pixel_if.sv
/*
 * One pixel's worth of layer codes and blanking, plus the pixel clock enable.
 * The top drives it through the source modport, the mixer reads the sink.
 */

`timescale 1ns/1ps

interface pixel_if;

    logic                            pxl_cen;  // one clk wide strobe
    logic [video_pkg::layer_w-1:0]   obj_pxl;  // sprite colour code, 0 is transparent
    logic [video_pkg::layer_w-1:0]   scr_pxl;  // tilemap colour code
    video_pkg::blank_t               blank;    // raw blanking levels

    // sampled on a rising clk edge with pxl_cen high
    modport source (
        output pxl_cen,
        output obj_pxl,
        output scr_pxl,
        output blank
    );

    modport sink (
        input pxl_cen,
        input obj_pxl,
        input scr_pxl,
        input blank
    );

endinterface

// File: hw/video_pkg.sv
/*
 * Pixel-side definitions for the Kicker colour mixer.
 * Holds the layer code widths, the blanking pair and the pipeline depth.
 * Files use these through scoped names.
 */

package video_pkg;

    // ########################################################################
    // layer codes
    // ########################################################################

    localparam int layer_w  = 4;  // sprite and scroll colour code width
    localparam int gfx_en_w = 4;  // layer debug enables, bit 0 scroll, bit 3 sprite

    // ########################################################################
    // blanking
    // ########################################################################

    // active-low levels, both high means visible area
    typedef struct packed {
        logic lhbl;  // horizontal blank, low during hblank
        logic lvbl;  // vertical blank, low during vblank
    } blank_t;

    // pxl_cen ticks from pixel in to colour out:
    // mux register, PROM read register, blank stage
    localparam int pipe_depth = 3;

endpackage

// File: kicker_video.f
hw/video_pkg.sv
hw/palette_pkg.sv
hw/pixel_if.sv
hw/palette_prom.sv
hw/blank_delay.sv
hw/kicker_colmix.sv
hw/kicker_video_top.sv
bench/kicker_video_tb.sv
